/* fetch_frontend.f */
+incdir+design
design/fetch_pkg.sv
design/pc_gen.sv
design/branch_scan.sv
design/return_stack.sv
design/branch_predict.sv
design/fetch_queue.sv
design/fetch_frontend.sv
tb/tb_clock_gen.sv
tb/tb_imem_model.sv
tb/tb_fetch_frontend.sv

/* tb/tb_fetch_frontend.sv */
`include "fetch_macros.svh"

module tb_fetch_frontend
  import fetch_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam addr_t BOOT             = 32'h0000_1000;
  localparam int    PERIOD_NS        = 40;
  localparam int    RESET_CYCLES     = 10;
  localparam int    NUM_ENTRIES      = 400;
  localparam int    CYCLES_PER_ENTRY = 10;
  localparam int    REDIRECT_GAP     = 30;

  logic         clk;
  logic         rst_n;
  resolve_t     resolve;
  logic         eret;
  addr_t        epc;
  logic         ex_valid;
  addr_t        trap_vector;
  imem_req_t    imem_req;
  imem_rsp_t    imem_rsp;
  fetch_entry_t fetch_entry;
  logic         fetch_valid;
  logic         fetch_ready;

  // reference model state
  addr_t        exp_pc;
  addr_t        ras_mirror[$];
  cf_e          exp_cf;
  logic         exp_taken;
  addr_t        exp_next;
  string        rule;
  int           entry_count;
  logic         prev_stall;
  logic         prev_redirect;
  fetch_entry_t prev_entry;
  logic         redirect_now;
  integer       seed = 6;

  tb_clock_gen #(.PERIOD_NS(PERIOD_NS), .RESET_CYCLES(RESET_CYCLES)) u_clock_gen (
    .clk_o (clk),
    .rst_no(rst_n)
  );

  tb_imem_model #(.BASE_ADDR(BOOT)) u_imem (
    .clk_i     (clk),
    .rst_ni    (rst_n),
    .imem_req_i(imem_req),
    .imem_rsp_o(imem_rsp)
  );

  fetch_frontend u_dut (
    .clk_i        (clk),
    .rst_ni       (rst_n),
    .boot_addr_i  (BOOT),
    .resolve_i    (resolve),
    .eret_i       (eret),
    .epc_i        (epc),
    .ex_valid_i   (ex_valid),
    .trap_vector_i(trap_vector),
    .imem_req_o   (imem_req),
    .imem_rsp_i   (imem_rsp),
    .fetch_entry_o(fetch_entry),
    .fetch_valid_o(fetch_valid),
    .fetch_ready_i(fetch_ready)
  );

  task automatic report_mismatch(input string name, input addr_t exp, input addr_t act);
    $display("Error %s expected %h actual %h", name, exp, act);
    $display("SIMULATION FAILED");
    $fatal(1, "check %s failed", name);
  endtask

  // program word as the memory holds it, fill outside the window
  function automatic addr_t expected_word(input addr_t addr);
    addr_t off;
    off = addr - BOOT;
    if (off < 32'd256) begin
      return u_imem.prog_q[off[7:2]];
    end else begin
      return {addr[31:7] ^ addr[24:0], 7'b0010011};
    end
  endfunction

  // ------------------------------------------------------------------------
  // reference prediction, static rule plus a mirrored return stack
  // ------------------------------------------------------------------------
  task automatic predict_model(input addr_t pc, input addr_t w);
    logic [4:0]         rd;
    logic [4:0]         rs1;
    logic signed [12:0] off_b;
    logic signed [20:0] off_j;
    logic signed [31:0] imm;
    logic               rd_link;
    logic               rs1_link;
    rd        = w[11:7];
    rs1       = w[19:15];
    off_b     = {w[31], w[7], w[30:25], w[11:8], 1'b0};
    off_j     = {w[31], w[19:12], w[20], w[30:21], 1'b0};
    rd_link   = (rd == 5'd1) || (rd == 5'd5);
    rs1_link  = (rs1 == 5'd1) || (rs1 == 5'd5);
    exp_cf    = CF_NONE;
    exp_taken = 1'b0;
    exp_next  = pc + 32'd4;
    rule      = "sequential";
    if (w[6:0] == `FE_OP_BRANCH) begin
      imm    = off_b;
      exp_cf = CF_BRANCH;
      rule   = "branch_forward";
      if (imm < 0) begin
        exp_taken = 1'b1;
        exp_next  = pc + imm;
        rule      = "branch_backward";
      end
    end else if (w[6:0] == `FE_OP_JAL) begin
      imm       = off_j;
      exp_cf    = CF_JUMP;
      exp_taken = 1'b1;
      exp_next  = pc + imm;
      rule      = "jal";
    end else if (w[6:0] == `FE_OP_JALR) begin
      exp_cf = CF_JALR;
      rule   = "jalr_indirect";
      if ((rd == 5'd0) && rs1_link) begin
        exp_cf = CF_RETURN;
        rule   = "return_empty";
        if (ras_mirror.size() > 0) begin
          exp_taken = 1'b1;
          exp_next  = ras_mirror[ras_mirror.size() - 1];
          ras_mirror.pop_back();
          rule = "return_stack";
        end
      end
    end
    // calls by jal or jalr push the link address, oldest drops when full
    if ((w[6:0] == `FE_OP_JAL || w[6:0] == `FE_OP_JALR) && rd_link) begin
      if (ras_mirror.size() == `FE_RAS_DEPTH) begin
        ras_mirror.delete(0);
      end
      ras_mirror.push_back(pc + 32'd4);
    end
  endtask

  task automatic check_entry();
    addr_t w;
    w = expected_word(exp_pc);
    assert (fetch_entry.pc == exp_pc)
      else report_mismatch("entry_pc", exp_pc, fetch_entry.pc);
    assert (fetch_entry.instr == w)
      else report_mismatch("entry_instr", w, fetch_entry.instr);
    predict_model(exp_pc, w);
    assert (fetch_entry.cf == exp_cf)
      else report_mismatch({"cf_class ", rule}, 32'(exp_cf), 32'(fetch_entry.cf));
    assert (fetch_entry.taken == exp_taken)
      else report_mismatch({"taken ", rule}, 32'(exp_taken), 32'(fetch_entry.taken));
    assert (fetch_entry.next_pc == exp_next)
      else report_mismatch({"next_pc ", rule}, exp_next, fetch_entry.next_pc);
    exp_pc = exp_next;
    entry_count <= entry_count + 1;
  endtask

  // mispredict over eret over exception
  function automatic addr_t redirect_target();
    if (resolve.valid && resolve.mispredict) begin
      return resolve.target;
    end else if (eret) begin
      return epc;
    end else begin
      return trap_vector;
    end
  endfunction

  // ------------------------------------------------------------------------
  // checker, samples everything at the rising edge
  // ------------------------------------------------------------------------
  always @(posedge clk) begin
    redirect_now = (resolve.valid && resolve.mispredict) || eret || ex_valid;
    if (!rst_n) begin
      assert (!imem_req.req && !fetch_valid)
        else report_mismatch("reset_idle", 32'd0, {30'd0, imem_req.req, fetch_valid});
      exp_pc = BOOT;
      ras_mirror.delete();
      prev_stall    = 1'b0;
      prev_redirect = 1'b0;
    end else begin
      // stalled head must not move
      if (prev_stall && !prev_redirect) begin
        assert (fetch_valid && (fetch_entry == prev_entry))
          else report_mismatch("held_entry", prev_entry.pc, fetch_entry.pc);
      end
      if (fetch_valid && fetch_ready) begin
        check_entry();
      end
      // a redirect flushes after any same-cycle transfer
      if (redirect_now) begin
        exp_pc = redirect_target();
        ras_mirror.delete();
      end
      prev_stall    = fetch_valid && !fetch_ready;
      prev_redirect = redirect_now;
      prev_entry    = fetch_entry;
    end
  end

  // decode takes an entry three cycles out of four
  always @(posedge clk) begin
    if (rst_n) begin
      fetch_ready <= ($random(seed) & 3) != 0;
    end
  end

  // ------------------------------------------------------------------------
  // redirect stimulus
  // ------------------------------------------------------------------------
  task automatic wait_for_accept();
    @(posedge clk);
    while (!(imem_req.req && imem_rsp.gnt)) begin
      @(posedge clk);
    end
  endtask

  task automatic drive_redirect(input int kind);
    resolve_t res;
    logic     er;
    logic     ex;
    res        = '0;
    res.target = BOOT + 32'd60;
    er         = 1'b0;
    ex         = 1'b0;
    case (kind)
      0: res.mispredict = 1'b1;
      1: er = 1'b1;
      2: ex = 1'b1;
      3: begin
        res.mispredict = 1'b1;
        er             = 1'b1;
        ex             = 1'b1;
      end
      4: begin
        er = 1'b1;
        ex = 1'b1;
      end
      // resolved but correct, so the exception wins
      default: ex = 1'b1;
    endcase
    res.valid   = res.mispredict || (kind == 5);
    resolve     <= res;
    eret        <= er;
    ex_valid    <= ex;
    epc         <= BOOT + 32'd124;
    trap_vector <= (kind == 6) ? 32'h0000_2000 : BOOT + 32'd88;
    @(posedge clk);
    resolve  <= '0;
    eret     <= 1'b0;
    ex_valid <= 1'b0;
  endtask

  initial begin
    resolve     = '0;
    eret        = 1'b0;
    epc         = '0;
    ex_valid    = 1'b0;
    trap_vector = '0;
    fetch_ready = 1'b0;
    entry_count = 0;
    @(posedge rst_n);
    for (int k = 0; k < NUM_ENTRIES / REDIRECT_GAP - 1; k++) begin
      while (entry_count < (k + 1) * REDIRECT_GAP) begin
        @(posedge clk);
      end
      // every other redirect hits a fetch in flight
      if (k % 2 == 1) begin
        wait_for_accept();
      end
      drive_redirect(k % 7);
    end
    while (entry_count < NUM_ENTRIES) begin
      @(posedge clk);
    end
    $display("SIMULATION PASSED");
    $finish;
  end

  // watchdog
  initial begin
    repeat (RESET_CYCLES + NUM_ENTRIES * CYCLES_PER_ENTRY) @(posedge clk);
    $display("timeout, only %0d entries reached decode", entry_count);
    $display("SIMULATION FAILED");
    $fatal(1, "watchdog expired");
  end

endmodule

/* tb/tb_imem_model.sv */
module tb_imem_model
  import fetch_pkg::*;
#(
  parameter addr_t BASE_ADDR = 32'h0000_1000
) (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  imem_req_t imem_req_i,
  output imem_rsp_t imem_rsp_o
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned Words = 64;

  addr_t      prog_q [Words];
  addr_t      addr_q;
  logic       busy_q;
  logic [1:0] gnt_cnt_q;
  logic [1:0] rsp_cnt_q;
  integer     seed = 6;

  // ------------------------------------------------------------------------
  // rv32 encoders for the control-flow words of the program
  // ------------------------------------------------------------------------
  // bne x0, x0 with a byte offset
  function automatic addr_t enc_branch(input logic [31:0] off);
    logic [12:0] o;
    o = off[12:0];
    return {o[12], o[10:5], 5'd0, 5'd0, 3'b001, o[4:1], o[11], 7'b1100011};
  endfunction

  function automatic addr_t enc_jal(input logic [4:0] rd, input logic [31:0] off);
    logic [20:0] o;
    o = off[20:0];
    return {o[20], o[10:1], o[11], o[19:12], rd, 7'b1101111};
  endfunction

  function automatic addr_t enc_jalr(input logic [4:0] rd, input logic [4:0] rs1,
                                     input logic [11:0] imm);
    return {imm, rs1, 3'b000, rd, 7'b1100111};
  endfunction

  // program window, outside of it every word is an addi built from the address
  function automatic addr_t word_at(input addr_t addr);
    addr_t off;
    off = addr - BASE_ADDR;
    if (off < 32'(Words * 4)) begin
      return prog_q[off[7:2]];
    end else begin
      return {addr[31:7] ^ addr[24:0], 7'b0010011};
    end
  endfunction

  // ------------------------------------------------------------------------
  // fixed program, word index in the comments
  // ------------------------------------------------------------------------
  initial begin
    // filler is addi x2, x2, index
    for (int i = 0; i < Words; i++) begin
      prog_q[i] = {12'(i), 5'd2, 3'b000, 5'd2, 7'b0010011};
    end
    prog_q[2]  = enc_branch(32'd12);
    // call through jalr x5, pushed but not predicted
    prog_q[3]  = enc_jalr(5'd5, 5'd10, 12'd0);
    prog_q[4]  = enc_jal(5'd0, 32'd8);
    // call to function a at 20
    prog_q[6]  = enc_jal(5'd1, 32'd56);
    // indirect jump, not a return
    prog_q[8]  = enc_jalr(5'd6, 5'd7, 12'd0);
    // loop 12..14, left only by a redirect
    prog_q[14] = enc_branch(-32'sd8);
    prog_q[16] = enc_jal(5'd0, -32'sd64);
    // nested call to function b at 30
    prog_q[21] = enc_jal(5'd1, 32'd36);
    prog_q[22] = enc_jalr(5'd0, 5'd1, 12'd0);
    prog_q[31] = enc_jalr(5'd0, 5'd1, 12'd0);
    prog_q[40] = enc_jal(5'd0, -32'sd160);
  end

  // ------------------------------------------------------------------------
  // grant and response with random extra delay of 0 to 3 cycles
  // ------------------------------------------------------------------------
  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      imem_rsp_o <= '0;
      addr_q     <= '0;
      busy_q     <= 1'b0;
      gnt_cnt_q  <= '0;
      rsp_cnt_q  <= '0;
    end else begin
      imem_rsp_o.rsp_valid <= 1'b0;
      if (imem_req_i.req && imem_rsp_o.gnt) begin
        // accepted, address is captured here
        imem_rsp_o.gnt <= 1'b0;
        busy_q         <= 1'b1;
        addr_q         <= imem_req_i.addr;
        rsp_cnt_q      <= 2'($random(seed));
      end else if (imem_req_i.req && !busy_q) begin
        if (gnt_cnt_q == '0) begin
          imem_rsp_o.gnt <= 1'b1;
          gnt_cnt_q      <= 2'($random(seed));
        end else begin
          gnt_cnt_q <= gnt_cnt_q - 1'b1;
        end
      end
      if (busy_q) begin
        if (rsp_cnt_q == '0) begin
          imem_rsp_o.rsp_valid <= 1'b1;
          imem_rsp_o.data      <= word_at(addr_q);
          busy_q               <= 1'b0;
        end else begin
          rsp_cnt_q <= rsp_cnt_q - 1'b1;
        end
      end
    end
  end

endmodule

/* tb/tb_clock_gen.sv */
module tb_clock_gen #(
  parameter int PERIOD_NS    = 40,
  parameter int RESET_CYCLES = 10
) (
  output logic clk_o,
  output logic rst_no
);
  timeunit 1ns;
  timeprecision 1ps;

  // free running clock, first rising edge at half a period
  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // reset falls shortly after time zero so the async reset sees a clean edge
  initial begin
    rst_no = 1'b1;
    #5;
    rst_no = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule

/* design/fetch_frontend.sv */
module fetch_frontend
  import fetch_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_ni,
  input  addr_t        boot_addr_i,
  input  resolve_t     resolve_i,
  input  logic         eret_i,
  input  addr_t        epc_i,
  input  logic         ex_valid_i,
  input  addr_t        trap_vector_i,
  output imem_req_t    imem_req_o,
  input  imem_rsp_t    imem_rsp_i,
  output fetch_entry_t fetch_entry_o,
  output logic         fetch_valid_o,
  input  logic         fetch_ready_i
);

  // response path from pc_gen
  logic         rsp_valid;
  addr_t        rsp_pc;
  addr_t        rsp_instr;
  logic         redirect;
  // scan and predict
  scan_t        scan;
  addr_t        next_pc;
  logic         push;
  fetch_entry_t entry;
  // queue back to pc_gen
  logic         slot_free;

  pc_gen u_pc_gen (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .boot_addr_i  (boot_addr_i),
    .resolve_i    (resolve_i),
    .eret_i       (eret_i),
    .ex_valid_i   (ex_valid_i),
    .epc_i        (epc_i),
    .trap_vector_i(trap_vector_i),
    .slot_free_i  (slot_free),
    .next_pc_i    (next_pc),
    .imem_req_o   (imem_req_o),
    .imem_rsp_i   (imem_rsp_i),
    .rsp_valid_o  (rsp_valid),
    .rsp_pc_o     (rsp_pc),
    .rsp_instr_o  (rsp_instr),
    .redirect_o   (redirect)
  );

  branch_scan u_branch_scan (
    .instr_i(rsp_instr),
    .scan_o (scan)
  );

  // redirect also empties the return stack
  branch_predict u_branch_predict (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .valid_i  (rsp_valid),
    .pc_i     (rsp_pc),
    .instr_i  (rsp_instr),
    .scan_i   (scan),
    .clear_i  (redirect),
    .push_o   (push),
    .entry_o  (entry),
    .next_pc_o(next_pc)
  );

  fetch_queue u_fetch_queue (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .flush_i      (redirect),
    .push_i       (push),
    .entry_i      (entry),
    .slot_free_o  (slot_free),
    .fetch_entry_o(fetch_entry_o),
    .fetch_valid_o(fetch_valid_o),
    .fetch_ready_i(fetch_ready_i)
  );

endmodule

/* design/fetch_queue.sv */
`include "fetch_macros.svh"

module fetch_queue
  import fetch_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         flush_i,
  input  logic         push_i,
  input  fetch_entry_t entry_i,
  output logic         slot_free_o,
  output fetch_entry_t fetch_entry_o,
  output logic         fetch_valid_o,
  input  logic         fetch_ready_i
);

  localparam int unsigned Depth = `FE_QUEUE_DEPTH;
  localparam int unsigned PtrW  = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntW  = $clog2(Depth + 1);

  fetch_entry_t    mem_q [Depth];
  logic [PtrW-1:0] rd_ptr_q;
  logic [PtrW-1:0] wr_ptr_q;
  logic [CntW-1:0] count_q;
  logic            do_push;
  logic            do_pop;

  // wrap a pointer at the last slot
  function automatic logic [PtrW-1:0] ptr_next(input logic [PtrW-1:0] p);
    return (p == PtrW'(Depth - 1)) ? '0 : p + 1'b1;
  endfunction

  // head entry stays put until decode takes it
  assign fetch_valid_o = (count_q != '0);
  assign fetch_entry_o = mem_q[rd_ptr_q];
  assign slot_free_o   = (count_q < CntW'(Depth));

  assign do_push = push_i & slot_free_o;
  assign do_pop  = fetch_valid_o & fetch_ready_i;

  // ---------------------------------------------------------------------------
  // pointers and fill count
  // ---------------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      // redirect drops everything fetched on the old path
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= ptr_next(wr_ptr_q);
      end
      if (do_pop) begin
        rd_ptr_q <= ptr_next(rd_ptr_q);
      end
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // storage
  always_ff @(posedge clk_i) begin
    if (do_push && !flush_i) begin
      mem_q[wr_ptr_q] <= entry_i;
    end
  end

endmodule

/* design/branch_predict.sv */
`include "fetch_macros.svh"

module branch_predict
  import fetch_pkg::*;
(
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                valid_i,
  input  addr_t               pc_i,
  input  logic [`FE_XLEN-1:0] instr_i,
  input  scan_t               scan_i,
  input  logic                clear_i,
  output logic                push_o,
  output fetch_entry_t        entry_o,
  output addr_t               next_pc_o
);

  addr_t pc_plus4;
  addr_t pc_target;
  logic  ras_push;
  logic  ras_pop;
  logic  ras_valid;
  addr_t ras_top;
  logic  taken;
  addr_t next_pc;

  assign pc_plus4  = pc_i + addr_t'(4);
  assign pc_target = pc_i + scan_i.imm;

  // calls save the return address, jalr calls included
  assign ras_push = valid_i & scan_i.is_call;
  // only a return that actually used the stack consumes it
  assign ras_pop  = valid_i & (scan_i.cf == CF_RETURN) & ras_valid;

  return_stack u_return_stack (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .clear_i    (clear_i),
    .push_i     (ras_push),
    .pop_i      (ras_pop),
    .push_addr_i(pc_plus4),
    .top_valid_o(ras_valid),
    .top_addr_o (ras_top)
  );

  // ---------------------------------------------------------------------------
  // static prediction
  // ---------------------------------------------------------------------------
  always_comb begin
    taken   = 1'b0;
    next_pc = pc_plus4;
    case (scan_i.cf)
      CF_BRANCH: begin
        // backward taken, forward not taken
        if (scan_i.imm[`FE_XLEN-1]) begin
          taken   = 1'b1;
          next_pc = pc_target;
        end
      end
      CF_JUMP: begin
        taken   = 1'b1;
        next_pc = pc_target;
      end
      CF_RETURN: begin
        if (ras_valid) begin
          taken   = 1'b1;
          next_pc = ras_top;
        end
      end
      // indirect jumps fall through without a btb
      default: begin
        taken = 1'b0;
      end
    endcase
  end

  // queue entry for decode
  assign entry_o.pc      = pc_i;
  assign entry_o.instr   = instr_i;
  assign entry_o.cf      = scan_i.cf;
  assign entry_o.taken   = taken;
  assign entry_o.next_pc = next_pc;

  assign push_o    = valid_i;
  assign next_pc_o = next_pc;

endmodule

/* design/return_stack.sv */
`include "fetch_macros.svh"

module return_stack
  import fetch_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  clear_i,
  input  logic  push_i,
  input  logic  pop_i,
  input  addr_t push_addr_i,
  output logic  top_valid_o,
  output addr_t top_addr_o
);

  localparam int unsigned Depth = `FE_RAS_DEPTH;
  localparam int unsigned PtrW  = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntW  = $clog2(Depth + 1);

  addr_t           mem_q [Depth];
  logic [PtrW-1:0] top_q;
  logic [PtrW-1:0] top_inc;
  logic [PtrW-1:0] top_dec;
  logic [CntW-1:0] count_q;

  // circular pointer steps
  assign top_inc = (top_q == PtrW'(Depth - 1)) ? '0 : top_q + 1'b1;
  assign top_dec = (top_q == '0) ? PtrW'(Depth - 1) : top_q - 1'b1;

  // top entry read without delay
  assign top_valid_o = (count_q != '0);
  assign top_addr_o  = mem_q[top_q];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      top_q   <= '0;
      count_q <= '0;
    end else if (clear_i) begin
      top_q   <= '0;
      count_q <= '0;
    end else if (push_i) begin
      top_q <= top_inc;
      // when full the oldest entry is overwritten and the count saturates
      if (count_q != CntW'(Depth)) begin
        count_q <= count_q + 1'b1;
      end
    end else if (pop_i && top_valid_o) begin
      top_q   <= top_dec;
      count_q <= count_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i && !clear_i) begin
      mem_q[top_inc] <= push_addr_i;
    end
  end

endmodule

/* design/branch_scan.sv */
`include "fetch_macros.svh"

module branch_scan
  import fetch_pkg::*;
(
  input  logic [`FE_XLEN-1:0] instr_i,
  output scan_t               scan_o
);

  logic [6:0] opcode;
  logic [4:0] rd;
  logic [4:0] rs1;
  addr_t      imm_b;
  addr_t      imm_j;
  addr_t      imm_i;
  logic       rd_link;
  logic       rs1_link;

  // x1 or x5 act as link register
  function automatic logic is_link(input logic [4:0] r);
    return (r == `FE_REG_RA) || (r == `FE_REG_T0);
  endfunction

  // ---------------------------------------------------------------------------
  // field extraction
  // ---------------------------------------------------------------------------
  assign opcode = instr_i[6:0];
  assign rd     = instr_i[11:7];
  assign rs1    = instr_i[19:15];

  // b-type offset, bit 0 always zero
  assign imm_b = {{(`FE_XLEN - 12){instr_i[31]}}, instr_i[7], instr_i[30:25],
                  instr_i[11:8], 1'b0};
  // j-type offset
  assign imm_j = {{(`FE_XLEN - 20){instr_i[31]}}, instr_i[19:12], instr_i[20],
                  instr_i[30:21], 1'b0};
  // i-type offset for jalr
  assign imm_i = {{(`FE_XLEN - 11){instr_i[31]}}, instr_i[30:20]};

  assign rd_link  = is_link(rd);
  assign rs1_link = is_link(rs1);

  // ---------------------------------------------------------------------------
  // classify
  // ---------------------------------------------------------------------------
  always_comb begin
    scan_o.cf      = CF_NONE;
    scan_o.is_call = 1'b0;
    scan_o.imm     = '0;
    case (opcode)
      `FE_OP_BRANCH: begin
        scan_o.cf  = CF_BRANCH;
        scan_o.imm = imm_b;
      end
      `FE_OP_JAL: begin
        scan_o.cf      = CF_JUMP;
        scan_o.imm     = imm_j;
        scan_o.is_call = rd_link;
      end
      `FE_OP_JALR: begin
        // jalr x0, 0(ra) style is a return, anything else is an indirect jump
        scan_o.cf      = ((rd == 5'd0) && rs1_link) ? CF_RETURN : CF_JALR;
        scan_o.imm     = imm_i;
        scan_o.is_call = rd_link;
      end
      default: begin
        scan_o.cf = CF_NONE;
      end
    endcase
  end

endmodule

/* design/pc_gen.sv */
`include "fetch_macros.svh"

module pc_gen
  import fetch_pkg::*;
(
  input  logic                clk_i,
  input  logic                rst_ni,
  input  addr_t               boot_addr_i,
  input  resolve_t            resolve_i,
  input  logic                eret_i,
  input  logic                ex_valid_i,
  input  addr_t               epc_i,
  input  addr_t               trap_vector_i,
  input  logic                slot_free_i,
  input  addr_t               next_pc_i,
  output imem_req_t           imem_req_o,
  input  imem_rsp_t           imem_rsp_i,
  output logic                rsp_valid_o,
  output addr_t               rsp_pc_o,
  output logic [`FE_XLEN-1:0] rsp_instr_o,
  output logic                redirect_o
);

  logic  run_q;
  addr_t pc_q;
  addr_t pc_d;
  addr_t fetch_pc;
  logic  outstanding_q;
  addr_t inflight_pc_q;
  logic  kill_q;
  logic  mispredict;
  addr_t redirect_pc;
  logic  accept;
  logic  rsp_arrive;

  // ---------------------------------------------------------------------------
  // redirect select
  // ---------------------------------------------------------------------------
  assign mispredict = resolve_i.valid & resolve_i.mispredict;
  assign redirect_o = mispredict | eret_i | ex_valid_i;

  // mispredict wins over eret, eret over exception
  always_comb begin
    if (mispredict) begin
      redirect_pc = resolve_i.target;
    end else if (eret_i) begin
      redirect_pc = epc_i;
    end else begin
      redirect_pc = trap_vector_i;
    end
  end

  // ---------------------------------------------------------------------------
  // memory port
  // ---------------------------------------------------------------------------
  // boot address is the pc until the first clock after reset
  assign fetch_pc = run_q ? pc_q : boot_addr_i;

  // one request in flight, and only into a free queue slot
  assign imem_req_o.req  = run_q & slot_free_i & ~outstanding_q;
  assign imem_req_o.addr = fetch_pc;

  assign accept     = imem_req_o.req & imem_rsp_i.gnt;
  assign rsp_arrive = outstanding_q & imem_rsp_i.rsp_valid;

  // stale or same-cycle redirected responses never reach the scanner
  assign rsp_valid_o = rsp_arrive & ~kill_q & ~redirect_o;
  assign rsp_pc_o    = inflight_pc_q;
  assign rsp_instr_o = imem_rsp_i.data;

  // next pc, a redirect overrides the prediction
  always_comb begin
    pc_d = fetch_pc;
    if (redirect_o) begin
      pc_d = redirect_pc;
    end else if (rsp_valid_o) begin
      pc_d = next_pc_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      run_q         <= 1'b0;
      pc_q          <= '0;
      outstanding_q <= 1'b0;
      kill_q        <= 1'b0;
    end else begin
      run_q <= 1'b1;
      pc_q  <= pc_d;
      if (accept) begin
        outstanding_q <= 1'b1;
      end else if (rsp_arrive) begin
        outstanding_q <= 1'b0;
      end
      // a redirect with a fetch still in flight marks its response stale
      if (redirect_o && (accept || (outstanding_q && !rsp_arrive))) begin
        kill_q <= 1'b1;
      end else if (rsp_arrive) begin
        kill_q <= 1'b0;
      end
    end
  end

  // pc of the granted request
  always_ff @(posedge clk_i) begin
    if (accept) begin
      inflight_pc_q <= fetch_pc;
    end
  end

endmodule

/* design/fetch_pkg.sv */
`include "fetch_macros.svh"

package fetch_pkg;

  // plain address or instruction word
  typedef logic [`FE_XLEN-1:0] addr_t;

  // control-flow class of one fetched word
  typedef enum logic [2:0] {
    CF_NONE   = 3'd0,
    CF_BRANCH = 3'd1,
    CF_JUMP   = 3'd2,
    CF_JALR   = 3'd3,
    CF_RETURN = 3'd4
  } cf_e;

  // scanner result, imm already sign extended
  typedef struct packed {
    cf_e   cf;
    logic  is_call;
    addr_t imm;
  } scan_t;

  // one entry handed to decode
  typedef struct packed {
    addr_t pc;
    addr_t instr;
    cf_e   cf;
    logic  taken;
    addr_t next_pc;
  } fetch_entry_t;

  // resolved branch from execute
  typedef struct packed {
    logic  valid;
    logic  mispredict;
    addr_t target;
  } resolve_t;

  // request toward instruction memory
  typedef struct packed {
    logic  req;
    addr_t addr;
  } imem_req_t;

  // grant, response valid and read data from instruction memory
  typedef struct packed {
    logic  gnt;
    logic  rsp_valid;
    addr_t data;
  } imem_rsp_t;

endpackage

/* design/fetch_macros.svh */
`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

// address and instruction width
`define FE_XLEN 32

// fetch queue slots toward decode
`define FE_QUEUE_DEPTH 4

// return address stack entries
`define FE_RAS_DEPTH 2

// rv32 major opcodes seen by the scanner
`define FE_OP_BRANCH 7'b1100011
`define FE_OP_JAL 7'b1101111
`define FE_OP_JALR 7'b1100111

// link registers x1 and x5
`define FE_REG_RA 5'd1
`define FE_REG_T0 5'd5

`endif
